// ==== source/gb_io_pkg.sv ====
`default_nettype none
// ----------------------------------------
// io hub shared definitions
// addresses, region codes, sizes, vectors
// and the interrupt byte layout
// ----------------------------------------

package gb_io_pkg;

	// bus widths
	localparam int ADDR_W   = 16;
	localparam int DATA_W   = 8;
	localparam int REGION_W = 4;

	// decoded targets
	localparam logic [REGION_W-1:0] REG_NONE    = 4'd0;
	localparam logic [REGION_W-1:0] REG_WRAM    = 4'd1;
	localparam logic [REGION_W-1:0] REG_ZPRAM   = 4'd2;
	localparam logic [REGION_W-1:0] REG_IE      = 4'd3;
	localparam logic [REGION_W-1:0] REG_IF      = 4'd4;
	localparam logic [REGION_W-1:0] REG_JOY     = 4'd5;
	localparam logic [REGION_W-1:0] REG_WBANK   = 4'd6;
	localparam logic [REGION_W-1:0] REG_SPARE72 = 4'd7;
	localparam logic [REGION_W-1:0] REG_SPARE73 = 4'd8;
	localparam logic [REGION_W-1:0] REG_SPARE75 = 4'd9;

	// io page registers
	localparam logic [ADDR_W-1:0] ADDR_JOY     = 16'hFF00;
	localparam logic [ADDR_W-1:0] ADDR_IF      = 16'hFF0F;
	localparam logic [ADDR_W-1:0] ADDR_WBANK   = 16'hFF70; // svbk, cgb only
	localparam logic [ADDR_W-1:0] ADDR_SPARE72 = 16'hFF72;
	localparam logic [ADDR_W-1:0] ADDR_SPARE73 = 16'hFF73;
	localparam logic [ADDR_W-1:0] ADDR_SPARE75 = 16'hFF75;
	localparam logic [ADDR_W-1:0] ADDR_IE      = 16'hFFFF;
	localparam logic [ADDR_W-1:0] ZPRAM_BASE   = 16'hFF80;
	localparam logic [ADDR_W-1:0] WRAM_BASE    = 16'hC000;
	localparam logic [ADDR_W-1:0] WRAM_LIMIT   = 16'hFE00; // end of echo, exclusive

	// memory sizes
	localparam int WRAM_BANK_BYTES = 4096;
	localparam int WRAM_BANKS      = 8;
	localparam int BANK_W          = $clog2(WRAM_BANKS);
	localparam int OFFS_W          = $clog2(WRAM_BANK_BYTES);
	localparam int WRAM_AW         = BANK_W + OFFS_W; // 32 KB
	localparam int ZPRAM_BYTES     = 127;
	localparam int ZPRAM_AW        = $clog2(ZPRAM_BYTES);

	// interrupts, bit 0 has top priority
	localparam int IRQ_COUNT = 5;
	localparam logic [DATA_W-1:0] VEC_VBLANK = 8'h40;
	localparam logic [DATA_W-1:0] VEC_LCDC   = 8'h48;
	localparam logic [DATA_W-1:0] VEC_TIMER  = 8'h50;
	localparam logic [DATA_W-1:0] VEC_SERIAL = 8'h58;
	localparam logic [DATA_W-1:0] VEC_JOYPAD = 8'h60;
	localparam logic [DATA_W-1:0] VEC_NONE   = 8'h00;

	localparam int READ_LATENCY = 3; // rd strobe to rd_valid_o

	// ie/if byte, raw on the bus, flags inside the controller
	typedef union packed {
		logic [DATA_W-1:0] raw;
		struct packed {
			logic [DATA_W-IRQ_COUNT-1:0] unused;
			logic                        joypad;
			logic                        serial;
			logic                        timer;
			logic                        lcdc;
			logic                        vblank;
		} flags;
	} irq_byte_u;

endpackage

`default_nettype wire

// ==== source/gb_io_stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// pipeline stage link
// one bus operation per cycle, no stall
// ----------------------------------------

interface gb_io_stage_if import gb_io_pkg::*; ();

	logic                valid;  // operation present
	logic                wr;     // 1 write, 0 read
	logic [REGION_W-1:0] region; // decoded target
	logic [ADDR_W-1:0]   addr;
	logic [DATA_W-1:0]   data;   // write data or captured reg value

	// producing stage
	modport src (
		output valid,
		output wr,
		output region,
		output addr,
		output data
	);

	// consuming stage
	modport dst (
		input valid,
		input wr,
		input region,
		input addr,
		input data
	);

endinterface

`default_nettype wire

// ==== source/gb_io_irq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// interrupt controller
// edge capture into IF, IE mask, priority
// vector and clear on acknowledge
// ----------------------------------------

module gb_io_irq_ctrl import gb_io_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset_ss,
	input  logic [3:0]        joy_din_i,    // p10..p13, active low
	input  logic              vblank_irq_i,
	input  logic              lcdc_irq_i,
	input  logic              timer_irq_i,
	input  logic              serial_irq_i,
	input  logic              irq_ack_i,
	input  logic              ie_wr_i,
	input  logic              if_wr_i,
	input  irq_byte_u         wdata_i,
	output irq_byte_u         ie_o,
	output irq_byte_u         if_o,
	output logic              irq_o,
	output logic [DATA_W-1:0] irq_vec_o
);

	logic [3:0]           ev_now;
	logic [3:0]           ev_prev;   // last level of each event line
	logic                 ack_prev;
	logic [3:0]           joy_meta;
	logic [3:0]           joy_sync;
	logic [3:0]           joy_prev;
	logic [IRQ_COUNT-1:0] if_q;
	logic [IRQ_COUNT-1:0] clr;
	irq_byte_u            ie_q;
	irq_byte_u            set_u;
	irq_byte_u            pend_u;

	assign ev_now = {serial_irq_i, timer_irq_i, lcdc_irq_i, vblank_irq_i};

	// new requests this cycle
	always_comb begin
		set_u              = '0;
		set_u.flags.vblank = ev_now[0] & ~ev_prev[0]; // rising edges
		set_u.flags.lcdc   = ev_now[1] & ~ev_prev[1];
		set_u.flags.timer  = ev_now[2] & ~ev_prev[2];
		set_u.flags.serial = ev_now[3] & ~ev_prev[3];
		set_u.flags.joypad = |(joy_prev & ~joy_sync); // any line pulled low
	end

	assign pend_u.raw = {{(DATA_W-IRQ_COUNT){1'b0}}, ie_q.raw[IRQ_COUNT-1:0] & if_q};

	// lowest set bit of pending, only on ack falling
	assign clr = (ack_prev & ~irq_ack_i)
		? pend_u.raw[IRQ_COUNT-1:0] & (~pend_u.raw[IRQ_COUNT-1:0] + 1'b1)
		: '0;

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ev_prev  <= '0;
			ack_prev <= 1'b0;
			joy_meta <= '1;   // lines idle high
			joy_sync <= '1;
			joy_prev <= '1;
			if_q     <= '0;
			ie_q     <= '0;
		end else begin
			ev_prev  <= ev_now;
			ack_prev <= irq_ack_i;
			joy_meta <= joy_din_i;
			joy_sync <= joy_meta;
			joy_prev <= joy_sync;
			// bus write has the last word
			if (if_wr_i)
				if_q <= wdata_i.raw[IRQ_COUNT-1:0];
			else
				if_q <= (if_q | set_u.raw[IRQ_COUNT-1:0]) & ~clr;
			if (ie_wr_i)
				ie_q <= wdata_i; // all 8 bits kept
		end
	end

	assign ie_o  = ie_q;
	assign if_o  = irq_byte_u'({{(DATA_W-IRQ_COUNT){1'b1}}, if_q}); // unused bits read 1
	assign irq_o = |pend_u.raw;

	// priority vector, vblank first
	always_comb begin
		if (pend_u.flags.vblank)
			irq_vec_o = VEC_VBLANK;
		else if (pend_u.flags.lcdc)
			irq_vec_o = VEC_LCDC;
		else if (pend_u.flags.timer)
			irq_vec_o = VEC_TIMER;
		else if (pend_u.flags.serial)
			irq_vec_o = VEC_SERIAL;
		else if (pend_u.flags.joypad)
			irq_vec_o = VEC_JOYPAD;
		else
			irq_vec_o = VEC_NONE;
	end

endmodule

`default_nettype wire

// ==== source/gb_io_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// stage 1, request decode
// registers the cpu strobe and sorts the
// address into a target region
// ----------------------------------------

module gb_io_decode import gb_io_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset_ss,
	input  logic              cgb_i,   // static strap
	input  logic              rd_i,
	input  logic              wr_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [DATA_W-1:0] wdata_i,
	gb_io_stage_if.src        out
);

	logic [REGION_W-1:0] region_d;

	// ----------------------------------------
	// address map
	// ----------------------------------------
	always_comb begin
		region_d = REG_NONE;
		if (addr_i >= WRAM_BASE && addr_i < WRAM_LIMIT) begin
			region_d = REG_WRAM; // c000-dfff plus e000-fdff echo
		end else if (addr_i >= ZPRAM_BASE && addr_i != ADDR_IE) begin
			region_d = REG_ZPRAM; // ff80-fffe
		end else begin
			case (addr_i)
				ADDR_IE:      region_d = REG_IE;
				ADDR_IF:      region_d = REG_IF;
				ADDR_JOY:     region_d = REG_JOY;
				// cgb extras, open bus on dmg
				ADDR_WBANK:   region_d = cgb_i ? REG_WBANK : REG_NONE;
				ADDR_SPARE72: region_d = cgb_i ? REG_SPARE72 : REG_NONE;
				ADDR_SPARE73: region_d = cgb_i ? REG_SPARE73 : REG_NONE;
				ADDR_SPARE75: region_d = cgb_i ? REG_SPARE75 : REG_NONE;
				default:      region_d = REG_NONE;
			endcase
		end
	end

	// ----------------------------------------
	// stage register
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			out.valid <= 1'b0;
		end else begin
			out.valid <= rd_i | wr_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		out.wr     <= wr_i; // write wins if both strobes high
		out.region <= region_d;
		out.addr   <= addr_i;
		out.data   <= wdata_i;
	end

endmodule

`default_nettype wire

// ==== source/gb_io_access.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// stage 2, access
// performs writes, reads the rams and
// captures register values for stage 3
// ----------------------------------------

module gb_io_access import gb_io_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset_ss,
	input  logic              cgb_i,
	input  logic [3:0]        joy_din_i,
	input  logic              vblank_irq_i,
	input  logic              lcdc_irq_i,
	input  logic              timer_irq_i,
	input  logic              serial_irq_i,
	input  logic              irq_ack_i,
	gb_io_stage_if.dst        in,
	gb_io_stage_if.src        out,
	output logic [DATA_W-1:0] wram_q_o,
	output logic [DATA_W-1:0] zpram_q_o,
	output logic [1:0]        joy_p54_o,
	output logic              irq_o,
	output logic [DATA_W-1:0] irq_vec_o
);

	logic [DATA_W-1:0]   wram [WRAM_BANKS*WRAM_BANK_BYTES];
	logic [DATA_W-1:0]   zpram [ZPRAM_BYTES];
	logic [BANK_W-1:0]   wram_bank; // svbk
	logic [BANK_W-1:0]   bank_sel;
	logic [WRAM_AW-1:0]  wram_idx;
	logic [ZPRAM_AW-1:0] zp_idx;
	logic [1:0]          p54;
	logic [DATA_W-1:0]   ff72;
	logic [DATA_W-1:0]   ff73;
	logic [2:0]          ff75;      // only bits 6:4 exist
	logic                wr_op;
	logic [DATA_W-1:0]   reg_rd;
	irq_byte_u           irq_wdata;
	irq_byte_u           ie_rd;
	irq_byte_u           if_rd;

	assign wr_op           = in.valid & in.wr;
	assign irq_wdata.raw   = in.data;
	assign joy_p54_o       = p54;

	// ----------------------------------------
	// wram banking
	// ----------------------------------------
	always_comb begin
		if (!in.addr[OFFS_W])
			bank_sel = '0;              // lower 4 KB always bank 0
		else if (!cgb_i)
			bank_sel = BANK_W'(1);      // dmg, fixed
		else if (wram_bank == '0)
			bank_sel = BANK_W'(1);      // svbk 0 selects 1
		else
			bank_sel = wram_bank;
	end

	assign wram_idx = {bank_sel, in.addr[OFFS_W-1:0]};
	assign zp_idx   = in.addr[ZPRAM_AW-1:0];

	// rams, one access per cycle
	always_ff @(posedge clk_sys) begin
		if (wr_op && in.region == REG_WRAM)
			wram[wram_idx] <= in.data;
		wram_q_o <= wram[wram_idx];
	end

	always_ff @(posedge clk_sys) begin
		if (wr_op && in.region == REG_ZPRAM)
			zpram[zp_idx] <= in.data;
		zpram_q_o <= zpram[zp_idx];
	end

	// ----------------------------------------
	// small registers
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			wram_bank <= '0;
			p54       <= 2'b00;
			ff72      <= '0;
			ff73      <= '0;
			ff75      <= '0;
		end else if (wr_op) begin
			case (in.region)
				REG_WBANK:   wram_bank <= in.data[BANK_W-1:0];
				REG_JOY:     p54       <= in.data[5:4];   // select lines
				REG_SPARE72: ff72      <= in.data;
				REG_SPARE73: ff73      <= in.data;
				REG_SPARE75: ff75      <= in.data[6:4];
				default: ;
			endcase
		end
	end

	gb_io_irq_ctrl u_irq_ctrl (
		.clk_sys      (clk_sys),
		.reset_ss     (reset_ss),
		.joy_din_i    (joy_din_i),
		.vblank_irq_i (vblank_irq_i),
		.lcdc_irq_i   (lcdc_irq_i),
		.timer_irq_i  (timer_irq_i),
		.serial_irq_i (serial_irq_i),
		.irq_ack_i    (irq_ack_i),
		.ie_wr_i      (wr_op && in.region == REG_IE),
		.if_wr_i      (wr_op && in.region == REG_IF),
		.wdata_i      (irq_wdata),
		.ie_o         (ie_rd),
		.if_o         (if_rd),
		.irq_o        (irq_o),
		.irq_vec_o    (irq_vec_o)
	);

	// register read value, rams go on their own ports
	always_comb begin
		case (in.region)
			REG_JOY:     reg_rd = {2'b11, p54, joy_din_i};
			REG_WBANK:   reg_rd = {{(DATA_W-BANK_W){1'b1}}, wram_bank};
			REG_SPARE72: reg_rd = ff72;
			REG_SPARE73: reg_rd = ff73;
			REG_SPARE75: reg_rd = {1'b1, ff75, 4'b1111};
			REG_IE:      reg_rd = ie_rd.raw;
			REG_IF:      reg_rd = if_rd.raw;
			default:     reg_rd = '1;
		endcase
	end

	// ----------------------------------------
	// stage register
	// ----------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			out.valid <= 1'b0;
		else
			out.valid <= in.valid;
	end

	always_ff @(posedge clk_sys) begin
		out.wr     <= in.wr;
		out.region <= in.region;
		out.addr   <= in.addr;
		out.data   <= reg_rd;
	end

endmodule

`default_nettype wire

// ==== source/gb_io_respond.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// stage 3, respond
// picks the read byte and pulses valid
// ----------------------------------------

module gb_io_respond import gb_io_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset_ss,
	gb_io_stage_if.dst        in,
	input  logic [DATA_W-1:0] wram_q_i,  // same cycle as in
	input  logic [DATA_W-1:0] zpram_q_i,
	output logic              rd_valid_o,
	output logic [DATA_W-1:0] rd_data_o
);

	logic [DATA_W-1:0] rd_mux;
	logic              rd_op;

	assign rd_op = in.valid & ~in.wr; // writes answer nothing

	always_comb begin
		case (in.region)
			REG_WRAM:  rd_mux = wram_q_i;
			REG_ZPRAM: rd_mux = zpram_q_i;
			REG_NONE:  rd_mux = 8'hFF;     // unmapped
			default:   rd_mux = in.data;   // captured in stage 2
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			rd_valid_o <= 1'b0;
		else
			rd_valid_o <= rd_op;
	end

	// data held between reads
	always_ff @(posedge clk_sys) begin
		if (rd_op)
			rd_data_o <= rd_mux;
	end

endmodule

`default_nettype wire

// ==== source/gb_io_hub.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// io hub top
// decode, access and respond in a row
// ----------------------------------------

module gb_io_hub import gb_io_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset_ss,
	input  logic              cgb_i,
	// cpu bus
	input  logic              rd_i,
	input  logic              wr_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [DATA_W-1:0] wdata_i,
	output logic              rd_valid_o,
	output logic [DATA_W-1:0] rd_data_o,
	// joypad
	input  logic [3:0]        joy_din_i,
	output logic [1:0]        joy_p54_o,
	// interrupt sources and cpu side
	input  logic              vblank_irq_i,
	input  logic              lcdc_irq_i,
	input  logic              timer_irq_i,
	input  logic              serial_irq_i,
	input  logic              irq_ack_i,
	output logic              irq_o,
	output logic [DATA_W-1:0] irq_vec_o
);

	logic [DATA_W-1:0] wram_q;
	logic [DATA_W-1:0] zpram_q;

	gb_io_stage_if s1 (); // decode to access
	gb_io_stage_if s2 (); // access to respond

	gb_io_decode u_decode (
		.clk_sys  (clk_sys),
		.reset_ss (reset_ss),
		.cgb_i    (cgb_i),
		.rd_i     (rd_i),
		.wr_i     (wr_i),
		.addr_i   (addr_i),
		.wdata_i  (wdata_i),
		.out      (s1)
	);

	gb_io_access u_access (
		.clk_sys      (clk_sys),
		.reset_ss     (reset_ss),
		.cgb_i        (cgb_i),
		.joy_din_i    (joy_din_i),
		.vblank_irq_i (vblank_irq_i),
		.lcdc_irq_i   (lcdc_irq_i),
		.timer_irq_i  (timer_irq_i),
		.serial_irq_i (serial_irq_i),
		.irq_ack_i    (irq_ack_i),
		.in           (s1),
		.out          (s2),
		.wram_q_o     (wram_q),
		.zpram_q_o    (zpram_q),
		.joy_p54_o    (joy_p54_o),
		.irq_o        (irq_o),
		.irq_vec_o    (irq_vec_o)
	);

	gb_io_respond u_respond (
		.clk_sys    (clk_sys),
		.reset_ss   (reset_ss),
		.in         (s2),
		.wram_q_i   (wram_q),
		.zpram_q_i  (zpram_q),
		.rd_valid_o (rd_valid_o),
		.rd_data_o  (rd_data_o)
	);

endmodule

`default_nettype wire

// ==== dv/gb_io_hub_properties.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// io hub bus and interrupt properties
// read latency, irq/vector agreement,
// strobe exclusion and reset state
// ----------------------------------------

module gb_io_hub_properties import gb_io_pkg::*; (
	input logic              clk_sys,
	input logic              reset_ss,
	input logic              rd_i,
	input logic              wr_i,
	input logic              rd_valid_i,
	input logic              irq_i,
	input logic [DATA_W-1:0] irq_vec_i
);

	int unsigned assert_fails = 0; // read by the testbench monitor

	// every response belongs to a read exactly READ_LATENCY edges back
	a_rd_only_after_read: assert property (@(posedge clk_sys) disable iff (reset_ss)
		rd_valid_i |-> $past(rd_i && !wr_i, READ_LATENCY))
	else begin
		assert_fails++;
		$error("rd_valid_o high without a read READ_LATENCY cycles earlier");
	end

	a_read_answered: assert property (@(posedge clk_sys) disable iff (reset_ss)
		$past(rd_i && !wr_i, READ_LATENCY) |-> rd_valid_i)
	else begin
		assert_fails++;
		$error("read strobe got no rd_valid_o after READ_LATENCY cycles");
	end

	a_irq_matches_vec: assert property (@(posedge clk_sys) disable iff (reset_ss)
		irq_i == (irq_vec_i != VEC_NONE))
	else begin
		assert_fails++;
		$error("irq_o and irq_vec_o disagree");
	end

	a_no_rd_wr_overlap: assert property (@(posedge clk_sys) disable iff (reset_ss)
		!(rd_i && wr_i))
	else begin
		assert_fails++;
		$error("rd_i and wr_i high in the same cycle");
	end

	// sync reset clears outputs on the next cycle
	a_reset_state: assert property (@(posedge clk_sys)
		reset_ss |=> (!rd_valid_i && !irq_i))
	else begin
		assert_fails++;
		$error("rd_valid_o or irq_o high right after reset");
	end

endmodule

bind gb_io_hub gb_io_hub_properties u_props (
	.clk_sys    (clk_sys),
	.reset_ss   (reset_ss),
	.rd_i       (rd_i),
	.wr_i       (wr_i),
	.rd_valid_i (rd_valid_o),
	.irq_i      (irq_o),
	.irq_vec_i  (irq_vec_o)
);

`default_nettype wire

// ==== dv/gb_io_hub_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// io hub testbench
// directed tests of ram, banking, irq,
// joypad and cgb spare registers
// ----------------------------------------

module gb_io_hub_tb import gb_io_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int WAIT_LIMIT = 20;  // cycles for a response or a flag
	// rough test lengths in cycles
	localparam int MEM_CYC   = 120;
	localparam int BANK_CYC  = 160;
	localparam int IRQ_CYC   = 200;
	localparam int REGS_CYC  = 100;
	localparam int JOY_CYC   = 120;
	localparam int SPARE_CYC = 100;
	localparam int WD_CYCLES = MEM_CYC + BANK_CYC + IRQ_CYC + REGS_CYC
		+ JOY_CYC + SPARE_CYC + 200;

	logic              clk_sys;
	logic              reset_ss;
	logic              cgb_i;
	logic              rd_i;
	logic              wr_i;
	logic [ADDR_W-1:0] addr_i;
	logic [DATA_W-1:0] wdata_i;
	logic              rd_valid_o;
	logic [DATA_W-1:0] rd_data_o;
	logic [3:0]        joy_din_i;
	logic [1:0]        joy_p54_o;
	logic              vblank_irq_i;
	logic              lcdc_irq_i;
	logic              timer_irq_i;
	logic              serial_irq_i;
	logic              irq_ack_i;
	logic              irq_o;
	logic [DATA_W-1:0] irq_vec_o;

	integer            seed = 32'h3a68;
	string             test_name = "reset";
	int                edge_cnt = 0;
	// scoreboard, one entry per outstanding read
	logic [ADDR_W-1:0] exp_addr_q[$];
	logic [DATA_W-1:0] exp_data_q[$];
	bit                exp_flags_q[$];
	int                exp_edge_q[$];

	gb_io_hub u_dut (
		.clk_sys      (clk_sys),
		.reset_ss     (reset_ss),
		.cgb_i        (cgb_i),
		.rd_i         (rd_i),
		.wr_i         (wr_i),
		.addr_i       (addr_i),
		.wdata_i      (wdata_i),
		.rd_valid_o   (rd_valid_o),
		.rd_data_o    (rd_data_o),
		.joy_din_i    (joy_din_i),
		.joy_p54_o    (joy_p54_o),
		.vblank_irq_i (vblank_irq_i),
		.lcdc_irq_i   (lcdc_irq_i),
		.timer_irq_i  (timer_irq_i),
		.serial_irq_i (serial_irq_i),
		.irq_ack_i    (irq_ack_i),
		.irq_o        (irq_o),
		.irq_vec_o    (irq_vec_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) edge_cnt <= edge_cnt + 1;

	// ----------------------------------------
	// failure and compare tasks
	// ----------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string what, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s %s expected %02h actual %02h",
				test_name, what, exp, act));
	endtask

	task automatic check_flags(input string what, input irq_byte_u exp, input irq_byte_u act);
		if (act.raw !== exp.raw)
			abort_run($sformatf("FAILED %s %s expected %08b actual %08b",
				test_name, what, exp.raw, act.raw));
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("FAILED %s %s expected %0b actual %0b",
				test_name, what, exp, act));
	endtask

	// ----------------------------------------
	// bus and pin drivers
	// ----------------------------------------
	task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		@(posedge clk_sys);
		wr_i    <= 1'b1;
		rd_i    <= 1'b0;
		addr_i  <= a;
		wdata_i <= d;
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] exp,
		input bit as_flags);
		@(posedge clk_sys);
		rd_i   <= 1'b1;
		wr_i   <= 1'b0;
		addr_i <= a;
		exp_addr_q.push_back(a);
		exp_data_q.push_back(exp);
		exp_flags_q.push_back(as_flags);
		exp_edge_q.push_back(edge_cnt + 2); // counter not bumped yet, DUT samples next edge
	endtask

	task automatic bus_idle();
		@(posedge clk_sys);
		rd_i <= 1'b0;
		wr_i <= 1'b0;
	endtask

	task automatic wait_reads_done();
		int n;
		n = 0;
		while (exp_data_q.size() != 0 && n < WAIT_LIMIT) begin
			@(posedge clk_sys);
			n++;
		end
		if (exp_data_q.size() != 0)
			abort_run($sformatf("%s: %0d read responses never arrived",
				test_name, exp_data_q.size()));
	endtask

	// poll until the vector settles, irq_o must agree with it
	task automatic wait_vec(input logic [DATA_W-1:0] exp);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (irq_vec_o !== exp && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		check_byte("irq_vec_o", exp, irq_vec_o);
		check_bit("irq_o", exp != VEC_NONE, irq_o);
	endtask

	task automatic pulse_ack();
		@(posedge clk_sys);
		irq_ack_i <= 1'b1;
		@(posedge clk_sys);
		irq_ack_i <= 1'b0; // falling edge clears one flag
	endtask

	task automatic apply_reset(input bit cgb);
		@(posedge clk_sys);
		reset_ss <= 1'b1;
		cgb_i    <= cgb;   // strap only changes under reset
		repeat (4) @(posedge clk_sys);
		reset_ss <= 1'b0;
	endtask

	// response monitor, outputs stable at the falling edge
	always @(negedge clk_sys) begin
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] exp;
		bit                as_flags;
		int                issued;
		if (u_dut.u_props.assert_fails != 0)
			abort_run("a bound assertion on the DUT failed");
		if (rd_valid_o === 1'b1) begin
			if (exp_data_q.size() == 0)
				abort_run($sformatf("%s: rd_valid_o pulsed with no read outstanding",
					test_name));
			a        = exp_addr_q.pop_front();
			exp      = exp_data_q.pop_front();
			as_flags = exp_flags_q.pop_front();
			issued   = exp_edge_q.pop_front();
			// next rising edge is the one that sees rd_valid_o
			if (edge_cnt + 1 - issued != READ_LATENCY)
				abort_run($sformatf("%s: read of %04h answered %0d edges after sampling",
					test_name, a, edge_cnt + 1 - issued));
			if (as_flags)
				check_flags($sformatf("read %04h", a), irq_byte_u'(exp),
					irq_byte_u'(rd_data_o));
			else
				check_byte($sformatf("read %04h", a), exp, rd_data_o);
		end
	end

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic test_memories();
		logic [ADDR_W-1:0] wa [8];
		logic [ADDR_W-1:0] za [8];
		logic [DATA_W-1:0] wd [8];
		logic [DATA_W-1:0] zd [8];
		test_name = "memories";
		for (int i = 0; i < 8; i++) begin
			// one 1 KB block each, so no two writes collide
			wa[i] = WRAM_BASE + ADDR_W'(i << 10) + ADDR_W'($random(seed) & 'h1FF);
			za[i] = ZPRAM_BASE + ADDR_W'(i * 18); // last one is fffe
			wd[i] = DATA_W'($random(seed));
			zd[i] = DATA_W'($random(seed));
			bus_write(wa[i], wd[i]);
			bus_write(za[i], zd[i]);
		end
		for (int i = 0; i < 8; i++) begin
			bus_read(wa[i], wd[i], 1'b0);
			bus_read(wa[i] + 16'h2000, wd[i], 1'b0); // echo window
			bus_read(za[i], zd[i], 1'b0);
		end
		bus_read(16'hFF7F, 8'hFF, 1'b0); // unmapped io
		bus_read(16'hFF01, 8'hFF, 1'b0);
		bus_read(16'hFF74, 8'hFF, 1'b0);
		bus_read(16'hFE00, 8'hFF, 1'b0);
		bus_idle();
		wait_reads_done();
	endtask

	task automatic test_wram_banks();
		logic [DATA_W-1:0] bank_val;
		test_name = "wram_banks";
		for (int b = 1; b < WRAM_BANKS; b++) begin
			bus_write(ADDR_WBANK, DATA_W'(b));
			bus_write(16'hD123, DATA_W'(16 + b));
		end
		bus_write(16'hC123, 8'h3C);       // lower half, bank 0
		bus_write(ADDR_WBANK, 8'h00);
		bus_write(16'hD124, 8'h5A);       // svbk 0 lands in bank 1
		for (int b = 0; b < WRAM_BANKS; b++) begin
			bank_val = (b == 0) ? 8'h11 : DATA_W'(16 + b);
			bus_write(ADDR_WBANK, DATA_W'(b));
			bus_read(ADDR_WBANK, 8'hF8 | DATA_W'(b), 1'b0);
			bus_read(16'hD123, bank_val, 1'b0);
			bus_read(16'hF123, bank_val, 1'b0); // echo follows bank
			bus_read(16'hC123, 8'h3C, 1'b0);
		end
		bus_write(ADDR_WBANK, 8'h01);
		bus_read(16'hD124, 8'h5A, 1'b0);
		bus_idle();
		wait_reads_done();
		// dmg, bank 1 fixed and no svbk
		apply_reset(1'b0);
		bus_read(ADDR_WBANK, 8'hFF, 1'b0);
		bus_read(16'hD123, 8'h11, 1'b0);
		bus_write(ADDR_WBANK, 8'h05);
		bus_read(16'hD123, 8'h11, 1'b0);
		bus_read(16'hD124, 8'h5A, 1'b0);
		bus_idle();
		wait_reads_done();
	endtask

	task automatic test_irq_priority();
		test_name = "irq_priority";
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_IE, 8'h1F);
		bus_idle();
		@(posedge clk_sys);
		vblank_irq_i <= 1'b1;
		lcdc_irq_i   <= 1'b1;
		timer_irq_i  <= 1'b1;
		serial_irq_i <= 1'b1;
		wait_vec(VEC_VBLANK);
		bus_read(ADDR_IE, 8'h1F, 1'b1);
		bus_read(ADDR_IF, 8'hEF, 1'b1);   // upper three read 1
		bus_idle();
		wait_reads_done();
		@(posedge clk_sys);
		vblank_irq_i <= 1'b0;             // falling edges set nothing
		lcdc_irq_i   <= 1'b0;
		timer_irq_i  <= 1'b0;
		serial_irq_i <= 1'b0;
		pulse_ack();
		wait_vec(VEC_LCDC);
		pulse_ack();
		wait_vec(VEC_TIMER);
		pulse_ack();
		wait_vec(VEC_SERIAL);
		pulse_ack();
		wait_vec(VEC_NONE);
		bus_read(ADDR_IF, 8'hE0, 1'b1);
		bus_idle();
		wait_reads_done();
	endtask

	task automatic test_irq_regs();
		test_name = "irq_regs";
		bus_write(ADDR_IE, 8'hA5);        // vblank and timer enabled
		bus_write(ADDR_IF, 8'h0A);        // lcdc and serial pending
		bus_read(ADDR_IE, 8'hA5, 1'b1);
		bus_read(ADDR_IF, 8'hEA, 1'b1);
		bus_idle();
		wait_reads_done();
		repeat (4) @(negedge clk_sys);
		check_bit("irq_o while masked", 1'b0, irq_o);
		bus_write(ADDR_IF, 8'h04);
		bus_idle();
		wait_vec(VEC_TIMER);
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_IE, 8'h00);
		bus_idle();
		wait_vec(VEC_NONE);
	endtask

	task automatic test_joypad();
		test_name = "joypad";
		bus_write(ADDR_JOY, 8'h20);
		bus_read(ADDR_JOY, 8'hEF, 1'b0);
		bus_idle();
		wait_reads_done();
		check_byte("joy_p54_o", 8'h02, {6'b0, joy_p54_o});
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_IE, 8'h10);
		bus_idle();
		@(posedge clk_sys);
		joy_din_i <= 4'b1101;             // one key pressed
		wait_vec(VEC_JOYPAD);
		bus_read(ADDR_IF, 8'hF0, 1'b1);
		bus_read(ADDR_JOY, 8'hED, 1'b0);
		bus_idle();
		wait_reads_done();
		@(posedge clk_sys);
		joy_din_i <= 4'hF;
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_IE, 8'h00);
		bus_idle();
		wait_vec(VEC_NONE);
	endtask

	task automatic test_spare_regs();
		logic [DATA_W-1:0] r72;
		logic [DATA_W-1:0] r73;
		logic [DATA_W-1:0] r75;
		test_name = "spare_regs";
		apply_reset(1'b1);
		r72 = DATA_W'($random(seed));
		r73 = DATA_W'($random(seed));
		r75 = DATA_W'($random(seed));
		bus_write(ADDR_SPARE72, r72);
		bus_write(ADDR_SPARE73, r73);
		bus_write(ADDR_SPARE75, r75);
		bus_read(ADDR_SPARE72, r72, 1'b0);
		bus_read(ADDR_SPARE73, r73, 1'b0);
		bus_read(ADDR_SPARE75, {1'b1, r75[6:4], 4'hF}, 1'b0); // only 6:4 stored
		bus_idle();
		wait_reads_done();
		apply_reset(1'b0);
		bus_write(ADDR_SPARE72, r72);
		bus_read(ADDR_SPARE72, 8'hFF, 1'b0);
		bus_read(ADDR_SPARE73, 8'hFF, 1'b0);
		bus_read(ADDR_SPARE75, 8'hFF, 1'b0);
		bus_idle();
		wait_reads_done();
	endtask

	// ----------------------------------------
	// run control
	// ----------------------------------------
	initial begin
		repeat (WD_CYCLES) #(CLK_PERIOD);
		abort_run($sformatf("watchdog expired after %0d cycles, the tests hung", WD_CYCLES));
	end

	initial begin
		reset_ss     = 1'b1;
		cgb_i        = 1'b1;
		rd_i         = 1'b0;
		wr_i         = 1'b0;
		addr_i       = '0;
		wdata_i      = '0;
		joy_din_i    = 4'hF;   // no key pressed
		vblank_irq_i = 1'b0;
		lcdc_irq_i   = 1'b0;
		timer_irq_i  = 1'b0;
		serial_irq_i = 1'b0;
		irq_ack_i    = 1'b0;
		apply_reset(1'b1);
		test_memories();
		test_wram_banks();
		test_irq_priority();
		test_irq_regs();
		test_joypad();
		test_spare_regs();
		repeat (2) @(posedge clk_sys);
		if (u_dut.u_props.assert_fails == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			abort_run("assertion failures were counted at the end of the run");
		end
	end

endmodule

`default_nettype wire

// ==== gb_io_hub.f ====
source/gb_io_pkg.sv
source/gb_io_stage_if.sv
source/gb_io_irq_ctrl.sv
source/gb_io_decode.sv
source/gb_io_access.sv
source/gb_io_respond.sv
source/gb_io_hub.sv
dv/gb_io_hub_properties.sv
dv/gb_io_hub_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the io hub testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module gb_io_hub_tb -f gb_io_hub.f

# the testbench stops itself on failure, the grep below decides
out=$(./obj_dir/Vgb_io_hub_tb +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TESTS PASSED"; then
	exit 0
fi
echo "simulation did not pass"
exit 1
